//--- src/mem_bridge_pkg.sv
/*
  Types shared by the memory-command bridge RTL.
  The bus is fixed at 64 bits because the bus word union is built on it.
  Only uncached single-word reads and writes are encoded.
  Sizes above one bus word do not exist.
*/
`default_nettype none

package mem_bridge_pkg;

  // bytes per bus word and derived widths
  localparam int unsigned bus_bytes_gp  = 8;
  localparam int unsigned bus_width_gp  = bus_bytes_gp * 8;
  localparam int unsigned bus_offset_gp = $clog2(bus_bytes_gp);

  // command kind
  typedef enum logic {
    e_uc_rd = 1'b0,
    e_uc_wr = 1'b1
  } msg_type_e;

  // access size, log2 of the byte count
  typedef enum logic [1:0] {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } msg_size_e;

  // one bus word, whole or lane by lane
  // lane 0 is the least significant byte
  typedef union packed {
    logic [bus_width_gp-1:0]      dword;
    logic [bus_bytes_gp-1:0][7:0] lane;
  } bus_word_u;

endpackage

`default_nettype wire

//--- src/cmd_buffer.sv
/*
  Two-entry command queue in front of the Wishbone master.
  The head stays stable until pop_i, so the master and the response
  packer may read its fields for the whole bus transfer.
  pop_i must only be pulsed while head_v_o is high.
*/
`timescale 1ns/10ps
`default_nettype none

module cmd_buffer
  import mem_bridge_pkg::*;
#(
  parameter int unsigned sram_addr_width_p = 10
) (
  input  wire logic                                       clk_i,
  input  wire logic                                       arst_n_i,
  input  wire logic                                       cmd_v_i,
  input  msg_type_e                                       cmd_type_i,
  input  msg_size_e                                       cmd_size_i,
  input  wire logic [sram_addr_width_p+bus_offset_gp-1:0] cmd_addr_i,
  input  wire logic [bus_width_gp-1:0]                    cmd_data_i,
  input  wire logic                                       pop_i,
  output logic                                            cmd_ready_o,
  output logic                                            head_v_o,
  output msg_type_e                                       head_type_o,
  output msg_size_e                                       head_size_o,
  output logic [sram_addr_width_p+bus_offset_gp-1:0]      head_addr_o,
  output logic [bus_width_gp-1:0]                         head_data_o
);

  localparam int unsigned addr_width_lp = sram_addr_width_p + bus_offset_gp;

  // entry storage, no reset needed on payload
  msg_type_e                type_mem [0:1];
  msg_size_e                size_mem [0:1];
  logic [addr_width_lp-1:0] addr_mem [0:1];
  logic [bus_width_gp-1:0]  data_mem [0:1];

  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       push;

  assign cmd_ready_o = (count_r != 2'd2);
  assign head_v_o    = (count_r != 2'd0);
  assign push        = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      type_mem[wr_ptr_r] <= cmd_type_i;
      size_mem[wr_ptr_r] <= cmd_size_i;
      addr_mem[wr_ptr_r] <= cmd_addr_i;
      data_mem[wr_ptr_r] <= cmd_data_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (pop_i) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      if (push && !pop_i) begin
        count_r <= count_r + 2'd1;
      end else if (!push && pop_i) begin
        count_r <= count_r - 2'd1;
      end
    end
  end

  // oldest entry
  assign head_type_o = type_mem[rd_ptr_r];
  assign head_size_o = size_mem[rd_ptr_r];
  assign head_addr_o = addr_mem[rd_ptr_r];
  assign head_data_o = data_mem[rd_ptr_r];

endmodule

`default_nettype wire

//--- src/wb_master_fsm.sv
/*
  Wishbone B4 classic master for single transfers.
  cyc and stb come from flops, so there is no combinational path from
  the target's ack back into the strobe.
  A transfer starts only when a command is waiting and the response
  side has room. The low three address bits are dropped, not checked.
  Sub-word accesses use the low byte lanes of the word.
*/
`timescale 1ns/10ps
`default_nettype none

module wb_master_fsm
  import mem_bridge_pkg::*;
#(
  parameter int unsigned sram_addr_width_p = 10
) (
  input  wire logic                                       clk_i,
  input  wire logic                                       arst_n_i,
  input  wire logic                                       head_v_i,
  input  msg_type_e                                       head_type_i,
  input  msg_size_e                                       head_size_i,
  input  wire logic [sram_addr_width_p+bus_offset_gp-1:0] head_addr_i,
  input  wire logic [bus_width_gp-1:0]                    head_data_i,
  input  wire logic                                       room_i,
  input  wire logic                                       ack_i,
  output logic                                            cyc_o,
  output logic                                            stb_o,
  output logic                                            we_o,
  output logic [bus_bytes_gp-1:0]                         sel_o,
  output logic [sram_addr_width_p-1:0]                    adr_o,
  output logic [bus_width_gp-1:0]                         dat_o
);

  typedef enum logic [1:0] {
    e_reset    = 2'b00,
    e_wait_cmd = 2'b01,
    e_wait_ack = 2'b10
  } state_e;

  state_e state_r;
  state_e state_n;
  logic   cyc_n;
  logic   stb_n;

  // bus fields straight from the head command
  assign we_o  = (head_type_i == e_uc_wr);
  assign adr_o = head_addr_i[sram_addr_width_p+bus_offset_gp-1:bus_offset_gp];
  assign dat_o = head_data_i;

  always_comb begin
    case (head_size_i)
      e_size_1: sel_o = 8'h01;
      e_size_2: sel_o = 8'h03;
      e_size_4: sel_o = 8'h0f;
      default:  sel_o = 8'hff;
    endcase
  end

  always_comb begin
    state_n = state_r;
    cyc_n   = 1'b0;
    stb_n   = 1'b0;
    case (state_r)
      e_reset: begin
        state_n = e_wait_cmd;
      end
      // start once a command and a response slot are both there
      e_wait_cmd: begin
        cyc_n = head_v_i & room_i;
        stb_n = head_v_i & room_i;
        if (stb_n) begin
          state_n = e_wait_ack;
        end
      end
      // hold the strobe through the ack cycle, drop it after
      e_wait_ack: begin
        cyc_n = ~ack_i;
        stb_n = ~ack_i;
        if (ack_i) begin
          state_n = e_wait_cmd;
        end
      end
      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= e_reset;
      cyc_o   <= 1'b0;
      stb_o   <= 1'b0;
    end else begin
      state_r <= state_n;
      cyc_o   <= cyc_n;
      stb_o   <= stb_n;
    end
  end

endmodule

`default_nettype wire

//--- src/resp_pack.sv
/*
  Response side of the bridge.
  On each ack the low bytes of the returned word, as many as the access
  size, are repeated across all 64 bits and queued with the echoed header.
  Holds up to two responses. room_o low means the master must wait.
  A push while full is not guarded here.
*/
`timescale 1ns/10ps
`default_nettype none

module resp_pack
  import mem_bridge_pkg::*;
#(
  parameter int unsigned sram_addr_width_p = 10
) (
  input  wire logic                                       clk_i,
  input  wire logic                                       arst_n_i,
  input  wire logic                                       ack_i,
  input  msg_type_e                                       head_type_i,
  input  msg_size_e                                       head_size_i,
  input  wire logic [sram_addr_width_p+bus_offset_gp-1:0] head_addr_i,
  input  wire logic [bus_width_gp-1:0]                    wb_dat_i,
  input  wire logic                                       resp_ready_i,
  output logic                                            room_o,
  output logic                                            resp_v_o,
  output msg_type_e                                       resp_type_o,
  output msg_size_e                                       resp_size_o,
  output logic [sram_addr_width_p+bus_offset_gp-1:0]      resp_addr_o,
  output logic [bus_width_gp-1:0]                         resp_data_o
);

  localparam int unsigned addr_width_lp = sram_addr_width_p + bus_offset_gp;

  msg_type_e                type_mem [0:1];
  msg_size_e                size_mem [0:1];
  logic [addr_width_lp-1:0] addr_mem [0:1];
  bus_word_u                data_mem [0:1];

  bus_word_u  raw_word;
  bus_word_u  rep_word;
  logic [2:0] lane_mask;
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       pop;

  // lane i takes byte (i mod size) of the returned word
  assign raw_word  = wb_dat_i;
  assign lane_mask = 3'((4'd1 << head_size_i) - 4'd1);

  always_comb begin
    for (int i = 0; i < bus_bytes_gp; i++) begin
      rep_word.lane[i] = raw_word.lane[3'(i) & lane_mask];
    end
  end

  assign room_o   = (count_r != 2'd2);
  assign resp_v_o = (count_r != 2'd0);
  assign pop      = resp_v_o & resp_ready_i;

  always_ff @(posedge clk_i) begin
    if (ack_i) begin
      type_mem[wr_ptr_r] <= head_type_i;
      size_mem[wr_ptr_r] <= head_size_i;
      addr_mem[wr_ptr_r] <= head_addr_i;
      data_mem[wr_ptr_r] <= rep_word;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (ack_i) wr_ptr_r <= ~wr_ptr_r;
      if (pop)   rd_ptr_r <= ~rd_ptr_r;
      if (ack_i && !pop) begin
        count_r <= count_r + 2'd1;
      end else if (!ack_i && pop) begin
        count_r <= count_r - 2'd1;
      end
    end
  end

  assign resp_type_o = type_mem[rd_ptr_r];
  assign resp_size_o = size_mem[rd_ptr_r];
  assign resp_addr_o = addr_mem[rd_ptr_r];
  assign resp_data_o = data_mem[rd_ptr_r].dword;

endmodule

`default_nettype wire

//--- src/wb_sram.sv
/*
  Wishbone B4 classic SRAM target, one word per address.
  ack is registered and pulses once per strobe, one cycle after stb.
  Writes touch only the lanes set in sel. The returned word is always
  the one stored before the access, also for writes.
  Memory contents are undefined after power up.
*/
`timescale 1ns/10ps
`default_nettype none

module wb_sram
  import mem_bridge_pkg::*;
#(
  parameter int unsigned sram_addr_width_p = 10
) (
  input  wire logic                         clk_i,
  input  wire logic                         arst_n_i,
  input  wire logic                         cyc_i,
  input  wire logic                         stb_i,
  input  wire logic                         we_i,
  input  wire logic [bus_bytes_gp-1:0]      sel_i,
  input  wire logic [sram_addr_width_p-1:0] adr_i,
  input  wire logic [bus_width_gp-1:0]      dat_i,
  output logic      [bus_width_gp-1:0]      dat_o,
  output logic                              ack_o
);

  localparam int unsigned depth_lp = 1 << sram_addr_width_p;

  bus_word_u mem [0:depth_lp-1];

  bus_word_u old_word;
  bus_word_u wr_word;
  bus_word_u new_word;
  logic      access;

  // first cycle of a strobe, ack not yet given
  assign access   = cyc_i & stb_i & ~ack_o;
  assign old_word = mem[adr_i];
  assign wr_word  = dat_i;

  // merge selected lanes over the stored word
  always_comb begin
    new_word = old_word;
    for (int i = 0; i < bus_bytes_gp; i++) begin
      if (sel_i[i]) new_word.lane[i] = wr_word.lane[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_o <= old_word.dword;
      if (we_i) mem[adr_i] <= new_word;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

endmodule

`default_nettype wire

//--- src/mem_bridge_top.sv
/*
  Uncached memory-command bridge with an SRAM target underneath.
  Both streams use valid/ready, and valid must not depend on ready.
  Addresses are byte addresses, and the low three bits are ignored.
  Responses leave in command order, one per command.
*/
`timescale 1ns/10ps
`default_nettype none

module mem_bridge_top
  import mem_bridge_pkg::*;
#(
  parameter int unsigned sram_addr_width_p = 10
) (
  input  wire logic                                       clk_i,
  input  wire logic                                       arst_n_i,
  input  wire logic                                       cmd_v_i,
  input  msg_type_e                                       cmd_type_i,
  input  msg_size_e                                       cmd_size_i,
  input  wire logic [sram_addr_width_p+bus_offset_gp-1:0] cmd_addr_i,
  input  wire logic [bus_width_gp-1:0]                    cmd_data_i,
  output logic                                            cmd_ready_o,
  output logic                                            resp_v_o,
  output msg_type_e                                       resp_type_o,
  output msg_size_e                                       resp_size_o,
  output logic [sram_addr_width_p+bus_offset_gp-1:0]      resp_addr_o,
  output logic [bus_width_gp-1:0]                         resp_data_o,
  input  wire logic                                       resp_ready_i
);

  localparam int unsigned addr_width_lp = sram_addr_width_p + bus_offset_gp;

  // head of the command queue
  logic                     head_v;
  msg_type_e                head_type;
  msg_size_e                head_size;
  logic [addr_width_lp-1:0] head_addr;
  logic [bus_width_gp-1:0]  head_data;
  logic                     room;

  // wishbone bus
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic [bus_bytes_gp-1:0]      wb_sel;
  logic [sram_addr_width_p-1:0] wb_adr;
  logic [bus_width_gp-1:0]      wb_dat_m2s;
  logic [bus_width_gp-1:0]      wb_dat_s2m;
  logic                         wb_ack;

  cmd_buffer #(.sram_addr_width_p(sram_addr_width_p)) cmd_buffer_i (
    .clk_i, .arst_n_i, .cmd_v_i, .cmd_type_i, .cmd_size_i, .cmd_addr_i, .cmd_data_i,
    .pop_i(wb_ack), .cmd_ready_o, .head_v_o(head_v), .head_type_o(head_type),
    .head_size_o(head_size), .head_addr_o(head_addr), .head_data_o(head_data)
  );

  wb_master_fsm #(.sram_addr_width_p(sram_addr_width_p)) wb_master_fsm_i (
    .clk_i, .arst_n_i, .head_v_i(head_v), .head_type_i(head_type),
    .head_size_i(head_size), .head_addr_i(head_addr), .head_data_i(head_data),
    .room_i(room), .ack_i(wb_ack), .cyc_o(wb_cyc), .stb_o(wb_stb), .we_o(wb_we),
    .sel_o(wb_sel), .adr_o(wb_adr), .dat_o(wb_dat_m2s)
  );

  resp_pack #(.sram_addr_width_p(sram_addr_width_p)) resp_pack_i (
    .clk_i, .arst_n_i, .ack_i(wb_ack), .head_type_i(head_type), .head_size_i(head_size),
    .head_addr_i(head_addr), .wb_dat_i(wb_dat_s2m), .resp_ready_i, .room_o(room),
    .resp_v_o, .resp_type_o, .resp_size_o, .resp_addr_o, .resp_data_o
  );

  wb_sram #(.sram_addr_width_p(sram_addr_width_p)) wb_sram_i (
    .clk_i, .arst_n_i, .cyc_i(wb_cyc), .stb_i(wb_stb), .we_i(wb_we), .sel_i(wb_sel),
    .adr_i(wb_adr), .dat_i(wb_dat_m2s), .dat_o(wb_dat_s2m), .ack_o(wb_ack)
  );

endmodule

`default_nettype wire

//--- tb/mem_bridge_tb.sv
/*
  Testbench for the memory-command bridge with its SRAM target.
  The byte reference memory is updated when a command is accepted, which
  holds because commands execute in order. The SRAM is not cleared, so
  reads only touch words that were written before.
*/
`timescale 1ns/10ps
`default_nettype none

module mem_bridge_tb
  import mem_bridge_pkg::*;
();

  localparam int unsigned aw_lp = 10;
  localparam int unsigned cw_lp = aw_lp + bus_offset_gp;

  logic             clk_i = 1'b0;
  logic             arst_n_i;
  logic             cmd_v_i;
  msg_type_e        cmd_type_i;
  msg_size_e        cmd_size_i;
  logic [cw_lp-1:0] cmd_addr_i;
  logic [63:0]      cmd_data_i;
  logic             cmd_ready_o;
  logic             resp_v_o;
  msg_type_e        resp_type_o;
  msg_size_e        resp_size_o;
  logic [cw_lp-1:0] resp_addr_o;
  logic [63:0]      resp_data_o;
  logic             resp_ready_i;

  // reference memory and expected responses with the oldest first
  logic [7:0]       ref_mem [0:(1<<cw_lp)-1];
  msg_type_e        exp_type_q [$];
  msg_size_e        exp_size_q [$];
  logic [cw_lp-1:0] exp_addr_q [$];
  logic [63:0]      exp_data_q [$];

  int   seed;
  int   errors;
  int   checks;
  int   resp_count;
  int   err_mark;
  logic rand_ready;

  mem_bridge_top #(.sram_addr_width_p(aw_lp)) mem_bridge_top_i (.*);

  always #4 clk_i = ~clk_i;

  // a response that is not taken must stay as it is
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && resp_type_o == $past(resp_type_o)
      && resp_size_o == $past(resp_size_o) && resp_addr_o == $past(resp_addr_o)
      && resp_data_o == $past(resp_data_o))
  else begin
    $display("response changed while resp_ready_i was low at %0t", $time);
    errors++;
  end

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // responses are compared on the edge where they are taken
  always @(posedge clk_i) begin
    if (arst_n_i && resp_v_o && resp_ready_i) begin
      if (exp_type_q.size() == 0) begin
        $display("unexpected response at %0t, no command outstanding", $time);
        errors++;
      end else begin
        compare_value("resp_type_o", 64'(resp_type_o), 64'(exp_type_q[0]));
        compare_value("resp_size_o", 64'(resp_size_o), 64'(exp_size_q[0]));
        compare_value("resp_addr_o", 64'(resp_addr_o), 64'(exp_addr_q[0]));
        if (exp_type_q[0] == e_uc_rd) begin
          compare_value("resp_data_o", resp_data_o, exp_data_q[0]);
        end
        exp_type_q.delete(0);
        exp_size_q.delete(0);
        exp_addr_q.delete(0);
        exp_data_q.delete(0);
        resp_count++;
      end
    end
  end

  task automatic next_negedge();
    @(negedge clk_i);
    if (rand_ready) resp_ready_i = (($random(seed) & 3) != 0);
  endtask

  task automatic abort_run(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("Test failed");
    $finish;
  endtask

  task automatic send_cmd(input msg_type_e t, input msg_size_e s,
                          input logic [cw_lp-1:0] a, input logic [63:0] d);
    int               n;
    int               cnt;
    logic [63:0]      exp;
    logic [cw_lp-1:0] idx;
    n = 1 << s;
    cnt = 0;
    cmd_v_i = 1'b1;
    cmd_type_i = t;
    cmd_size_i = s;
    cmd_addr_i = a;
    cmd_data_i = d;
    // ready does not look at valid, so it is settled on the falling edge
    while (!cmd_ready_o && cnt < 100) begin
      next_negedge();
      cnt++;
    end
    if (!cmd_ready_o) abort_run("cmd_ready_o");
    // old word with its low lanes repeated over the whole bus word
    for (int i = 0; i < 8; i++) begin
      idx = {a[cw_lp-1:3], 3'(i % n)};
      exp[8*i +: 8] = ref_mem[idx];
    end
    if (t == e_uc_wr) begin
      for (int i = 0; i < n; i++) begin
        idx = {a[cw_lp-1:3], 3'(i)};
        ref_mem[idx] = d[8*i +: 8];
      end
    end
    exp_type_q.push_back(t);
    exp_size_q.push_back(s);
    exp_addr_q.push_back(a);
    exp_data_q.push_back(exp);
    next_negedge();
    cmd_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_type_q.size() != 0 && cnt < 2000) begin
      next_negedge();
      cnt++;
    end
    if (exp_type_q.size() != 0) abort_run("outstanding responses");
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  function automatic logic [63:0] fill_pattern(input int w);
    return {32'(w) * 32'h9e3779b1, ~(32'(w) * 32'h85ebca6b)};
  endfunction

  initial begin
    int               cnt;
    int               gap;
    logic [cw_lp-1:0] ra;
    logic [63:0]      rd;
    msg_type_e        rt;
    msg_size_e        rs;
    seed = 32'h3bb07b61;
    errors = 0;
    checks = 0;
    resp_count = 0;
    err_mark = 0;
    rand_ready = 1'b0;
    arst_n_i = 1'b1;
    cmd_v_i = 1'b0;
    cmd_type_i = e_uc_rd;
    cmd_size_i = e_size_8;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    resp_ready_i = 1'b1;
    #1 arst_n_i = 1'b0;
    for (int c = 0; c < 13; c++) begin
      next_negedge();
      if (c == 9) arst_n_i = 1'b1;
      compare_value("resp_v_o", 64'(resp_v_o), 64'd0);
      compare_value("cmd_ready_o", 64'(cmd_ready_o), 64'd1);
    end
    end_test("reset");
    send_cmd(e_uc_wr, e_size_8, 13'h040, 64'h0123_4567_89ab_cdef);
    send_cmd(e_uc_rd, e_size_8, 13'h040, '0);
    wait_drain();
    end_test("full word");
    // each sub-word write to word 20 is followed by a full read
    send_cmd(e_uc_wr, e_size_8, 13'h0a0, 64'hffee_ddcc_bbaa_9988);
    send_cmd(e_uc_wr, e_size_1, 13'h0a0, 64'h1111_1111_1111_1101);
    send_cmd(e_uc_rd, e_size_8, 13'h0a0, '0);
    send_cmd(e_uc_wr, e_size_2, 13'h0a0, 64'h2222_2222_2222_0202);
    send_cmd(e_uc_rd, e_size_8, 13'h0a0, '0);
    send_cmd(e_uc_wr, e_size_4, 13'h0a0, 64'h3333_3333_0403_0201);
    send_cmd(e_uc_rd, e_size_8, 13'h0a0, '0);
    wait_drain();
    end_test("sub-word write");
    send_cmd(e_uc_rd, e_size_1, 13'h0a3, '0);
    send_cmd(e_uc_rd, e_size_2, 13'h0a6, '0);
    send_cmd(e_uc_rd, e_size_4, 13'h0a1, '0);
    wait_drain();
    end_test("sub-word read");
    // two held in the packer and two in the command queue
    resp_ready_i = 1'b0;
    send_cmd(e_uc_wr, e_size_8, 13'h040, 64'h5555_aaaa_5555_aaaa);
    send_cmd(e_uc_rd, e_size_4, 13'h0a0, '0);
    send_cmd(e_uc_rd, e_size_8, 13'h040, '0);
    send_cmd(e_uc_wr, e_size_2, 13'h0a0, 64'h7777);
    cnt = 0;
    while (cmd_ready_o && cnt < 50) begin
      next_negedge();
      cnt++;
    end
    if (cmd_ready_o) abort_run("cmd_ready_o to fall");
    repeat (8) next_negedge();
    resp_ready_i = 1'b1;
    wait_drain();
    end_test("backpressure");
    for (int w = 0; w < 64; w++) send_cmd(e_uc_wr, e_size_8, {10'(w), 3'd0}, fill_pattern(w));
    rand_ready = 1'b1;
    for (int k = 0; k < 200; k++) begin
      gap = $random(seed) & 3;
      ra = 13'($random(seed)) & 13'h1ff;
      rd[63:32] = $random(seed);
      rd[31:0] = $random(seed);
      rt = msg_type_e'($random(seed) & 1);
      rs = msg_size_e'($random(seed) & 3);
      repeat (gap) next_negedge();
      send_cmd(rt, rs, ra, rd);
    end
    wait_drain();
    rand_ready = 1'b0;
    resp_ready_i = 1'b1;
    end_test("random");
    $display("checks %0d, responses %0d, errors %0d", checks, resp_count, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
src/mem_bridge_pkg.sv
src/cmd_buffer.sv
src/wb_master_fsm.sv
src/resp_pack.sv
src/wb_sram.sv
src/mem_bridge_top.sv
tb/mem_bridge_tb.sv

//--- run.sh
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mem_bridge_tb -f flist.f

out=$(./obj_dir/Vmem_bridge_tb)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
  exit 0
else
  exit 1
fi
